//--- design/cache_addr_pkg.sv
// cache address layout
`default_nettype none

package cache_addr_pkg;

	localparam int ADDR_BITS = 32;

	// one 64-bit word per line
	localparam int OFFSET_BITS = 3;
	localparam int SET_BITS = 3;
	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;

	// tag, then set index, then byte offset
	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [SET_BITS-1:0] set_idx;
		logic [OFFSET_BITS-1:0] offset;
	} cache_addr_fields_t;

	// same byte address seen whole or split
	typedef union packed {
		logic [ADDR_BITS-1:0] raw;
		cache_addr_fields_t fields;
	} cache_addr_u;

endpackage

`default_nettype wire

//--- design/victim_pkg.sv
// victim line types
`default_nettype none

package victim_pkg;

	localparam int DATA_BITS = 64;

	// evicted line, carries enough to rebuild its address
	typedef struct packed {
		logic [cache_addr_pkg::TAG_BITS-1:0] tag;
		logic [cache_addr_pkg::SET_BITS-1:0] set_idx;
		logic [DATA_BITS-1:0] data;
	} victim_entry_t;

endpackage

`default_nettype wire

//--- design/victim_if.sv
// cache to victim buffer link
`timescale 1ns/10ps
`default_nettype none

interface victim_if;
	import victim_pkg::*;

	// displaced line, pushed at the edge where evict is high
	logic evict;
	victim_entry_t evict_entry;

	// array half of the read lookup
	logic array_hit;
	logic [DATA_BITS-1:0] array_data;

	modport array (
		output evict,
		output evict_entry,
		output array_hit,
		output array_data
	);

	modport buffer (
		input evict,
		input evict_entry,
		input array_hit,
		input array_data
	);

endinterface

`default_nettype wire

//--- design/cache_sets.sv
// set-associative line array
`timescale 1ns/10ps
`default_nettype none

module cache_sets #(
	parameter int NUM_WAYS = 4
) (
	input logic clock,
	input logic reset,
	input logic rd_en,
	input logic wr_en,
	input cache_addr_pkg::cache_addr_u rd_addr,
	input cache_addr_pkg::cache_addr_u wr_addr,
	input logic [63:0] wr_data,
	victim_if.array victims
);
	import cache_addr_pkg::*;
	import victim_pkg::*;

	localparam int WAY_BITS = $clog2(NUM_WAYS);
	localparam int NODES = NUM_WAYS - 1;

	logic [TAG_BITS-1:0] line_tag [NUM_SETS][NUM_WAYS];
	logic [DATA_BITS-1:0] line_data [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] line_valid [NUM_SETS];

	// tree bits per set, heap order, 0 points left
	logic [NODES-1:0] plru [NUM_SETS];
	logic [NODES-1:0] plru_next [NUM_SETS];

	logic [SET_BITS-1:0] rd_set;
	logic [SET_BITS-1:0] wr_set;
	logic [NUM_WAYS-1:0] rd_hits;
	logic [NUM_WAYS-1:0] wr_hits;
	logic [WAY_BITS-1:0] rd_way;
	logic [WAY_BITS-1:0] hit_way;
	logic [WAY_BITS-1:0] free_way;
	logic [WAY_BITS-1:0] lru_way;
	logic [WAY_BITS-1:0] wr_way;
	logic rd_hit;
	logic wr_hit;
	logic has_free;

	// point every node on the path away from the way
	function automatic logic [NODES-1:0] touch(
		input logic [NODES-1:0] bits,
		input logic [WAY_BITS-1:0] way
	);
		logic [NODES-1:0] result;
		int node;
		result = bits;
		node = 0;
		for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
			result[node] = ~way[WAY_BITS-1-lvl];
			node = 2 * node + 1 + int'(way[WAY_BITS-1-lvl]);
		end
		return result;
	endfunction

	// follow the node bits down from the root
	function automatic logic [WAY_BITS-1:0] plru_pick(input logic [NODES-1:0] bits);
		logic [WAY_BITS-1:0] way;
		int node;
		way = '0;
		node = 0;
		for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
			way[WAY_BITS-1-lvl] = bits[node];
			node = 2 * node + 1 + int'(bits[node]);
		end
		return way;
	endfunction

	assign rd_set = rd_addr.fields.set_idx;
	assign wr_set = wr_addr.fields.set_idx;

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			rd_hits[w] = line_valid[rd_set][w] && line_tag[rd_set][w] == rd_addr.fields.tag;
			wr_hits[w] = line_valid[wr_set][w] && line_tag[wr_set][w] == wr_addr.fields.tag;
		end
	end

	// descending scan, so the lowest invalid way is kept
	always_comb begin
		rd_way = '0;
		hit_way = '0;
		free_way = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (rd_hits[w])
				rd_way = WAY_BITS'(w);
			if (wr_hits[w])
				hit_way = WAY_BITS'(w);
			if (!line_valid[wr_set][w])
				free_way = WAY_BITS'(w);
		end
	end

	assign rd_hit = |rd_hits;
	assign wr_hit = |wr_hits;
	assign has_free = ~&line_valid[wr_set];
	assign lru_way = plru_pick(plru[wr_set]);

	// hit, else first invalid, else tree victim
	assign wr_way = wr_hit ? hit_way : (has_free ? free_way : lru_way);

	// full set and a miss means the tree victim leaves
	assign victims.evict = wr_en & ~wr_hit & ~has_free;
	assign victims.evict_entry = '{
		tag: line_tag[wr_set][lru_way],
		set_idx: wr_set,
		data: line_data[wr_set][lru_way]
	};

	assign victims.array_hit = rd_en & rd_hit;
	assign victims.array_data = line_data[rd_set][rd_way];

	// write touch first, read touch on top of it
	always_comb begin
		plru_next = plru;
		if (wr_en)
			plru_next[wr_set] = touch(plru[wr_set], wr_way);
		if (rd_en && rd_hit)
			plru_next[rd_set] = touch(plru_next[rd_set], rd_way);
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			line_tag[wr_set][wr_way] <= wr_addr.fields.tag;
			line_data[wr_set][wr_way] <= wr_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				line_valid[s] <= '0;
				plru[s] <= '0;
			end
		end else begin
			if (wr_en)
				line_valid[wr_set][wr_way] <= 1'b1;
			plru <= plru_next;
		end
	end

	// a tag never sits in two ways of one set
	assert property (@(posedge clock) disable iff (reset)
		$onehot0(rd_hits) && $onehot0(wr_hits));

endmodule

`default_nettype wire

//--- design/victim_buffer.sv
// victim FIFO with read search
`timescale 1ns/10ps
`default_nettype none

module victim_buffer #(
	parameter int VICTIM_DEPTH = 4
) (
	input logic clock,
	input logic reset,
	input logic rd_en,
	input cache_addr_pkg::cache_addr_u rd_addr,
	victim_if.buffer victims,
	input logic pop,
	output logic head_valid,
	output victim_pkg::victim_entry_t head_entry,
	output logic victim_full,
	output logic rd_valid,
	output logic rd_miss,
	output logic [63:0] rd_data
);
	import victim_pkg::*;

	localparam int PTR_BITS = $clog2(VICTIM_DEPTH);
	localparam int CNT_BITS = $clog2(VICTIM_DEPTH + 1);

	victim_entry_t entries [VICTIM_DEPTH];
	logic [PTR_BITS-1:0] head;
	logic [PTR_BITS-1:0] tail;
	logic [CNT_BITS-1:0] count;

	// slot holding the k-th oldest entry
	logic [PTR_BITS-1:0] slot [VICTIM_DEPTH];
	logic buf_hit;
	logic [DATA_BITS-1:0] buf_data;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(VICTIM_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (victims.evict)
			entries[tail] <= victims.evict_entry;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (victims.evict)
				tail <= next_ptr(tail);
			if (pop)
				head <= next_ptr(head);
			case ({victims.evict, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_comb begin
		for (int k = 0; k < VICTIM_DEPTH; k++)
			slot[k] = PTR_BITS'((int'(head) + k) % VICTIM_DEPTH);
	end

	// oldest to newest, so the newest match wins
	always_comb begin
		buf_hit = 1'b0;
		buf_data = '0;
		for (int k = 0; k < VICTIM_DEPTH; k++) begin
			if (k < int'(count) &&
				entries[slot[k]].tag == rd_addr.fields.tag &&
				entries[slot[k]].set_idx == rd_addr.fields.set_idx) begin
				buf_hit = 1'b1;
				buf_data = entries[slot[k]].data;
			end
		end
	end

	assign head_valid = count != '0;
	assign head_entry = entries[head];
	assign victim_full = count == CNT_BITS'(VICTIM_DEPTH);

	// array copy is newer than anything held here
	assign rd_valid = rd_en & (victims.array_hit | buf_hit);
	assign rd_miss = rd_en & ~victims.array_hit & ~buf_hit;
	assign rd_data = victims.array_hit ? victims.array_data : buf_data;

	// array must not evict into a full buffer
	assert property (@(posedge clock) disable iff (reset)
		victim_full |-> !victims.evict);

	// write-back port drains only what is held
	assert property (@(posedge clock) disable iff (reset)
		!head_valid |-> !pop);

endmodule

`default_nettype wire

//--- design/writeback_port.sv
// victim drain to memory
`timescale 1ns/10ps
`default_nettype none

module writeback_port (
	input logic clock,
	input logic reset,
	input logic head_valid,
	input victim_pkg::victim_entry_t head_entry,
	input logic mem_busy,
	output logic pop,
	output logic mem_wr_en,
	output cache_addr_pkg::cache_addr_u mem_addr,
	output logic [63:0] mem_wr_data
);
	import cache_addr_pkg::*;

	cache_addr_u line_addr;

	// drain whenever memory takes a write
	assign pop = head_valid & ~mem_busy;

	// word address from the victim's tag and set
	always_comb begin
		line_addr.fields.tag = head_entry.tag;
		line_addr.fields.set_idx = head_entry.set_idx;
		line_addr.fields.offset = '0;
	end

	always_ff @(posedge clock) begin
		if (reset)
			mem_wr_en <= 1'b0;
		else
			mem_wr_en <= pop;
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			mem_addr.raw <= line_addr.raw;
			mem_wr_data <= head_entry.data;
		end
	end

	// one pop gives a single-cycle write
	assert property (@(posedge clock) disable iff (reset)
		pop ##1 !pop |=> !mem_wr_en);

endmodule

`default_nettype wire

//--- design/dcache_top.sv
// data cache top level
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
	parameter int NUM_WAYS = 4,
	parameter int VICTIM_DEPTH = 4
) (
	input logic clock,
	input logic reset,
	input logic rd_en,
	input logic [31:0] rd_addr,
	output logic rd_valid,
	output logic [63:0] rd_data,
	output logic rd_miss,
	input logic wr_en,
	input logic [31:0] wr_addr,
	input logic [63:0] wr_data,
	output logic victim_full,
	input logic mem_busy,
	output logic mem_wr_en,
	output logic [31:0] mem_addr,
	output logic [63:0] mem_wr_data
);
	import victim_pkg::*;

	logic head_valid;
	victim_entry_t head_entry;
	logic pop;

	victim_if victims ();

	cache_sets #(
		.NUM_WAYS(NUM_WAYS)
	) i_sets (
		.clock(clock),
		.reset(reset),
		.rd_en(rd_en),
		.wr_en(wr_en),
		.rd_addr(rd_addr),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.victims(victims.array)
	);

	victim_buffer #(
		.VICTIM_DEPTH(VICTIM_DEPTH)
	) i_victims (
		.clock(clock),
		.reset(reset),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.victims(victims.buffer),
		.pop(pop),
		.head_valid(head_valid),
		.head_entry(head_entry),
		.victim_full(victim_full),
		.rd_valid(rd_valid),
		.rd_miss(rd_miss),
		.rd_data(rd_data)
	);

	writeback_port i_writeback (
		.clock(clock),
		.reset(reset),
		.head_valid(head_valid),
		.head_entry(head_entry),
		.mem_busy(mem_busy),
		.pop(pop),
		.mem_wr_en(mem_wr_en),
		.mem_addr(mem_addr),
		.mem_wr_data(mem_wr_data)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// released on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- testbench/dcache_tb.sv
// data cache testbench
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;
	import cache_addr_pkg::*;
	import victim_pkg::*;

	localparam int NUM_WAYS = 4;
	localparam int VICTIM_DEPTH = 4;
	localparam int WAY_BITS = $clog2(NUM_WAYS);
	localparam int NODES = NUM_WAYS - 1;
	localparam int RANDOM_CYCLES = 400;
	// reset, directed phases, random mix, drain and verdict
	localparam int SCHEDULED = 5 + 48 + RANDOM_CYCLES + 13;
	localparam int TIMEOUT_CYCLES = 4 * SCHEDULED + 200;

	logic clock;
	logic reset;
	logic rd_en;
	logic [31:0] rd_addr;
	logic rd_valid;
	logic [63:0] rd_data;
	logic rd_miss;
	logic wr_en;
	logic [31:0] wr_addr;
	logic [63:0] wr_data;
	logic victim_full;
	logic mem_busy;
	logic mem_wr_en;
	logic [31:0] mem_addr;
	logic [63:0] mem_wr_data;

	// reference model state
	logic [TAG_BITS-1:0] m_tag [NUM_SETS][NUM_WAYS];
	logic [63:0] m_data [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] m_valid [NUM_SETS];
	logic [NODES-1:0] m_plru [NUM_SETS];
	victim_entry_t vq [$];
	logic exp_wb_valid;
	victim_entry_t exp_wb;
	string test_name;
	int seed;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(4)) i_clock (.clock(clock), .reset(reset));

	dcache_top #(
		.NUM_WAYS(NUM_WAYS),
		.VICTIM_DEPTH(VICTIM_DEPTH)
	) i_dut (.*);

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_read(input logic exp_valid, input logic [63:0] exp_data,
		input logic act_valid, input logic [63:0] act_data);
		if (act_valid !== exp_valid || rd_miss !== (rd_en & ~exp_valid))
			stop_on_error($sformatf("FAILED %s read %h: expected valid %b, actual valid %b miss %b",
				test_name, rd_addr, exp_valid, act_valid, rd_miss));
		else if (exp_valid && act_data !== exp_data)
			stop_on_error($sformatf("FAILED %s read %h: expected %h, actual %h",
				test_name, rd_addr, exp_data, act_data));
	endtask

	task automatic check_writeback(input cache_addr_u exp_addr, input logic [63:0] exp_data,
		input cache_addr_u act_addr, input logic [63:0] act_data);
		if (act_addr.raw !== exp_addr.raw || act_data !== exp_data)
			stop_on_error($sformatf("FAILED %s write-back: expected %h %h, actual %h %h",
				test_name, exp_addr.raw, exp_data, act_addr.raw, act_data));
	endtask

	// five tags per set, one more than the ways
	function automatic logic [31:0] pool_addr(input int idx);
		cache_addr_u a;
		a.fields.tag = TAG_BITS'(32'h1c0 + idx % 40);
		a.fields.set_idx = SET_BITS'(idx % NUM_SETS);
		a.fields.offset = OFFSET_BITS'($random(seed));
		return a.raw;
	endfunction

	function automatic int find_way(input cache_addr_u a);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_valid[a.fields.set_idx][w] && m_tag[a.fields.set_idx][w] == a.fields.tag)
				return w;
		end
		return -1;
	endfunction

	// each node on the path points to the other half
	function automatic logic [NODES-1:0] plru_touch(input logic [NODES-1:0] bits, input int way);
		int node;
		int dir;
		node = 0;
		for (int lvl = WAY_BITS - 1; lvl >= 0; lvl--) begin
			dir = (way >> lvl) & 1;
			bits[node] = (dir == 0);
			node = 2 * node + 1 + dir;
		end
		return bits;
	endfunction

	function automatic int plru_victim(input logic [NODES-1:0] bits);
		int node;
		int way;
		node = 0;
		way = 0;
		for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
			way = 2 * way + int'(bits[node]);
			node = 2 * node + 1 + int'(bits[node]);
		end
		return way;
	endfunction

	// array first, else the newest buffered copy
	function automatic logic [64:0] expected_read(input cache_addr_u a);
		int w;
		w = find_way(a);
		if (w >= 0)
			return {1'b1, m_data[a.fields.set_idx][w]};
		for (int i = vq.size() - 1; i >= 0; i--) begin
			if (vq[i].tag == a.fields.tag && vq[i].set_idx == a.fields.set_idx)
				return {1'b1, vq[i].data};
		end
		return '0;
	endfunction

	// one clock edge: drain, write with eviction, then read touch
	task automatic model_edge();
		cache_addr_u ra;
		cache_addr_u wa;
		victim_entry_t v;
		int rway;
		int wway;
		int s;
		ra.raw = rd_addr;
		wa.raw = wr_addr;
		rway = find_way(ra);
		exp_wb_valid = vq.size() != 0 && !mem_busy;
		if (exp_wb_valid)
			exp_wb = vq.pop_front();
		if (wr_en) begin
			s = wa.fields.set_idx;
			wway = find_way(wa);
			if (wway < 0) begin
				for (int w = NUM_WAYS - 1; w >= 0; w--)
					if (!m_valid[s][w])
						wway = w;
			end
			if (wway < 0) begin
				wway = plru_victim(m_plru[s]);
				v.tag = m_tag[s][wway];
				v.set_idx = SET_BITS'(s);
				v.data = m_data[s][wway];
				vq.push_back(v);
			end
			m_tag[s][wway] = wa.fields.tag;
			m_data[s][wway] = wr_data;
			m_valid[s][wway] = 1'b1;
			m_plru[s] = plru_touch(m_plru[s], wway);
		end
		if (rd_en && rway >= 0)
			m_plru[ra.fields.set_idx] = plru_touch(m_plru[ra.fields.set_idx], rway);
	endtask

	// no write while the buffer is full
	task automatic cycle(input logic rd, input int ridx, input logic wr, input int widx,
		input logic [63:0] data, input logic busy);
		@(negedge clock);
		rd_en = rd;
		rd_addr = pool_addr(ridx);
		wr_en = wr && !victim_full;
		wr_addr = pool_addr(widx);
		wr_data = data;
		mem_busy = busy;
	endtask

	initial begin
		logic busy;
		int burst;
		seed = 32'h333d_1acf;
		rd_en = 1'b0;
		rd_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		mem_busy = 1'b0;
		test_name = "reset";
		@(negedge reset);
		for (int i = 0; i < 8; i++)
			cycle(1'b1, i, 1'b0, 0, '0, 1'b0);
		test_name = "fill_hit";
		for (int i = 0; i < NUM_WAYS; i++)
			cycle(1'b0, 0, 1'b1, 8 * i, 64'h1000 + i, 1'b0);
		for (int i = 0; i < NUM_WAYS; i++)
			cycle(1'b1, 8 * i, 1'b0, 0, '0, 1'b0);
		cycle(1'b0, 0, 1'b1, 8, 64'h2222, 1'b0);
		cycle(1'b1, 8, 1'b0, 0, '0, 1'b0);
		// fifth tag in set 0, mixed with read hits
		test_name = "plru";
		cycle(1'b1, 16, 1'b0, 0, '0, 1'b0);
		cycle(1'b1, 0, 1'b1, 32, 64'h3333, 1'b0);
		cycle(1'b1, 24, 1'b1, 0, 64'h4444, 1'b0);
		cycle(1'b1, 32, 1'b1, 16, 64'h5555, 1'b0);
		repeat (4)
			cycle(1'b1, 0, 1'b0, 0, '0, 1'b0);
		// memory busy, set 1 overflows and one tag leaves twice
		test_name = "victim";
		for (int i = 0; i < 5; i++)
			cycle(1'b0, 0, 1'b1, 1 + 8 * i, 64'h6000 + i, 1'b1);
		cycle(1'b0, 0, 1'b1, 1, 64'h7001, 1'b1);
		cycle(1'b1, 25, 1'b0, 0, '0, 1'b1);
		cycle(1'b1, 9, 1'b0, 0, '0, 1'b1);
		cycle(1'b1, 1, 1'b1, 17, 64'h7017, 1'b1);
		cycle(1'b1, 1, 1'b1, 1, 64'h7101, 1'b1);
		for (int i = 0; i < 4; i++)
			cycle(1'b1, 1 + 8 * i, 1'b1, 33, 64'h7133, 1'b1);
		for (int i = 0; i < 8; i++)
			cycle(1'b1, 1 + 8 * (i % 5), 1'b0, 0, '0, 1'b0);
		test_name = "random";
		busy = 1'b0;
		burst = 0;
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			// busy about a third of the bursts
			if (burst == 0) begin
				busy = ($unsigned($random(seed)) % 3) == 0;
				burst = 1 + $unsigned($random(seed)) % 12;
			end
			burst--;
			cycle($random(seed) % 4 != 0, $unsigned($random(seed)) % 40, $random(seed) & 1,
				$unsigned($random(seed)) % 40, {$random(seed), $random(seed)}, busy);
		end
		test_name = "drain";
		repeat (12)
			cycle(1'b0, 0, 1'b0, 0, '0, 1'b0);
		@(negedge clock);
		#10;
		$display("Everything OK");
		$finish;
	end

	// compare after each falling edge, then step the model over the next edge
	initial begin
		cache_addr_u exp_addr;
		logic [64:0] exp_rd;
		exp_wb_valid = 1'b0;
		for (int s = 0; s < NUM_SETS; s++) begin
			m_valid[s] = '0;
			m_plru[s] = '0;
		end
		forever begin
			@(negedge clock);
			#5;
			if (!reset) begin
				if (mem_wr_en !== exp_wb_valid)
					stop_on_error($sformatf("FAILED %s mem_wr_en: expected %b, actual %b",
						test_name, exp_wb_valid, mem_wr_en));
				if (exp_wb_valid) begin
					exp_addr.fields.tag = exp_wb.tag;
					exp_addr.fields.set_idx = exp_wb.set_idx;
					exp_addr.fields.offset = '0;
					check_writeback(exp_addr, exp_wb.data, mem_addr, mem_wr_data);
				end
				if (victim_full !== (vq.size() == VICTIM_DEPTH))
					stop_on_error($sformatf("FAILED %s victim_full: expected %b, actual %b",
						test_name, vq.size() == VICTIM_DEPTH, victim_full));
				exp_rd = rd_en ? expected_read(rd_addr) : '0;
				check_read(exp_rd[64], exp_rd[63:0], rd_valid, rd_data);
				model_edge();
			end
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clock);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				stop_on_error($sformatf("run timed out after %0d cycles", cycles));
		end
	end

endmodule

`default_nettype wire

//--- list.f
design/cache_addr_pkg.sv
design/victim_pkg.sv
design/victim_if.sv
design/cache_sets.sv
design/victim_buffer.sv
design/writeback_port.sv
design/dcache_top.sv
testbench/tb_clock_gen.sv
testbench/dcache_tb.sv
